// File: compile.f
+incdir+design
design/core_isa_pkg.sv
design/core_trace_pkg.sv
design/acc_core.sv
design/word_sram.sv
design/commit_tracer.sv
design/core_sys_top.sv
dv/core_sys_chk.sv
dv/core_sys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator from compile.f, run, and decide the result from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module core_sys_tb \
  -f compile.f -o core_sys_sim \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/core_sys_sim 2>&1 | tee sim.log

grep -qx "Simulation PASSED" sim.log \
  && echo "Run result: pass" \
  || { echo "Run result: fail, see sim.log"; exit 1; }

// File: dv/core_sys_tb.sv
`default_nettype none

`include "core_cfg.svh"

module core_sys_tb
  import core_isa_pkg::*;
  import core_trace_pkg::*;
();

  logic                clk_i;
  logic                rst_n_i;
  logic [`CORE_AW-1:0] boot_addr_i;
  logic                load_we_i;
  logic [`CORE_AW-1:0] load_addr_i;
  logic [`CORE_DW-1:0] load_data_i;
  exit_status_e        exit_status_o;
  logic [`CORE_DW-1:0] exit_code_o;
  logic [15:0]         retire_count_o;

  // Program image, mirrored into the DUT memory by the preload port
  logic [`CORE_DW-1:0] image [`MEM_WORDS];
  logic [`CORE_AW-1:0] emit_ptr;
  logic [31:0]         lfsr_q;

  exit_status_e        exp_status;
  logic [`CORE_DW-1:0] exp_code;
  logic [15:0]         exp_count;
  logic                test_checked = 1'b1;
  int                  run_budget = 0;

  core_sys_top u_dut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .boot_addr_i    (boot_addr_i),
    .load_we_i      (load_we_i),
    .load_addr_i    (load_addr_i),
    .load_data_i    (load_data_i),
    .exit_status_o  (exit_status_o),
    .exit_code_o    (exit_code_o),
    .retire_count_o (retire_count_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Random bits and program building
  // ----------------------------------------

  // Galois LFSR, x^32 + x^30 + x^26 + x^25 + 1
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ 32'hA300_0000;
    end
    return out;
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Unused words decode as opcode F, so a runaway fetch retires illegal
  task automatic new_image(input logic [7:0] start);
    for (int a = 0; a < `MEM_WORDS; a++) begin
      image[a] = {4'hF, ~a[3:0], a[7:0]};
    end
    emit_ptr = start;
  endtask

  task automatic emit(input logic [3:0] op, input logic [7:0] opd);
    image[emit_ptr] = {op, 4'h0, opd};
    emit_ptr = emit_ptr + 8'd1;
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  function automatic void ref_run(input logic [7:0] boot, output exit_status_e status,
                                  output logic [15:0] code, output logic [15:0] count);
    logic [15:0] m [`MEM_WORDS];
    logic [7:0]  pc;
    logic [15:0] acc;
    logic [15:0] insn;
    logic [7:0]  opd;
    int          steps;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      m[i] = image[i];
    end
    pc = boot;
    acc = '0;
    count = '0;
    code = '0;
    status = EXIT_NONE;
    steps = 0;
    while ((status == EXIT_NONE) && (steps < 4096)) begin
      insn = m[pc];
      opd = insn[7:0];
      count = count + 16'd1;
      steps++;
      case (insn[15:12])
        OP_LDI:  acc = {8'h00, opd};
        OP_ADDI: acc = acc + {8'h00, opd};
        OP_SUBI: acc = acc - {8'h00, opd};
        OP_LD:   acc = m[opd];
        OP_ST: begin
          m[opd] = acc;
          if (opd == `TOHOST_ADDR) begin
            status = EXIT_TOHOST;
            code = acc;
          end
        end
        OP_BNZ:  ;
        default: begin
          status = EXIT_ILLEGAL;
          code = {8'h00, pc};
        end
      endcase
      // Illegal keeps its PC, a taken branch jumps
      if ((insn[15:12] == OP_BNZ) && (acc != '0)) begin
        pc = opd;
      end else if (status != EXIT_ILLEGAL) begin
        pc = pc + 8'd1;
      end
    end
  endfunction

  // ----------------------------------------
  // Checks and test sequencing
  // ----------------------------------------

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%04h, expected 0x%04h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "Value check failed");
    end
  endtask

  task automatic preload_image();
    for (int a = 0; a < `MEM_WORDS; a++) begin
      @(posedge clk_i);
      load_we_i   <= 1'b1;
      load_addr_i <= a[7:0];
      load_data_i <= image[a];
    end
    @(posedge clk_i);
    load_we_i <= 1'b0;
  endtask

  task automatic run_test(input logic [7:0] boot);
    @(posedge clk_i);
    rst_n_i     <= 1'b0;
    boot_addr_i <= boot;
    preload_image();
    ref_run(boot, exp_status, exp_code, exp_count);
    run_budget = run_budget + 4 * int'(exp_count) + 200;
    test_checked = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    while (!test_checked) begin
      @(posedge clk_i);
    end
  endtask

  // Compares once the tracer leaves EXIT_NONE
  initial begin : compare_proc
    forever begin
      @(posedge clk_i);
      if (rst_n_i && !test_checked && (exit_status_o != EXIT_NONE)) begin
        check_value("exit_status_o", 16'(exit_status_o), 16'(exp_status));
        check_value("exit_code_o", exit_code_o, exp_code);
        check_value("retire_count_o", retire_count_o, exp_count);
        test_checked = 1'b1;
      end
    end
  end

  // Budget grows as each test is started, only run cycles count
  initial begin : watchdog
    int run_cycles;
    run_cycles = 0;
    forever begin
      @(posedge clk_i);
      if (rst_n_i) begin
        run_cycles++;
      end
      if (run_cycles > run_budget) begin
        $display("Timeout: the core never signalled an exit within %0d cycles", run_budget);
        $display("Simulation FAILED");
        $fatal(1, "Watchdog expired");
      end
    end
  end

  initial begin : stimulus
    logic [7:0] boot;
    int         len;
    int         op_sel;
    rst_n_i     = 1'b0;
    boot_addr_i = '0;
    load_we_i   = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    lfsr_q      = 32'd67222;

    // Straight line with 16-bit wraparound
    new_image(8'h00);
    emit(OP_LDI, 8'h05);
    emit(OP_SUBI, 8'h10);
    emit(OP_ADDI, 8'hC4);
    emit(OP_SUBI, 8'hFF);
    emit(OP_ST, `TOHOST_ADDR);
    run_test(8'h00);

    // Memory round trip through a scratch word
    new_image(8'h00);
    emit(OP_LDI, 8'h7A);
    emit(OP_ADDI, 8'h81);
    emit(OP_ST, 8'h80);
    emit(OP_LDI, 8'h00);
    emit(OP_LD, 8'h80);
    emit(OP_ADDI, 8'h11);
    emit(OP_ST, `TOHOST_ADDR);
    run_test(8'h00);

    // Countdown loop
    new_image(8'h00);
    emit(OP_LDI, 8'h05);
    emit(OP_SUBI, 8'h01);
    emit(OP_BNZ, 8'h01);
    emit(OP_ADDI, 8'h33);
    emit(OP_ST, `TOHOST_ADDR);
    run_test(8'h00);

    // Illegal opcode mid-program
    new_image(8'h00);
    emit(OP_LDI, 8'h03);
    emit(OP_ADDI, 8'h04);
    emit(4'h7, 8'h12);
    emit(OP_ST, `TOHOST_ADDR);
    run_test(8'h00);

    // Non-zero boot address
    new_image(8'h40);
    emit(OP_LDI, 8'h09);
    emit(OP_ST, 8'h90);
    emit(OP_LD, 8'h90);
    emit(OP_SUBI, 8'h02);
    emit(4'h0, 8'hBC);
    emit(OP_ST, `TOHOST_ADDR);
    run_test(8'h40);

    // Random straight-line programs, scratch in 0x80..0x9F
    for (int t = 0; t < 20; t++) begin
      boot = rand_bits(6);
      len = 3 + int'(rand_bits(3));
      new_image(boot);
      for (int i = 0; i < len; i++) begin
        op_sel = int'(rand_bits(3)) % 5;
        case (op_sel)
          0:       emit(OP_LDI, rand_bits(8));
          1:       emit(OP_ADDI, rand_bits(8));
          2:       emit(OP_SUBI, rand_bits(8));
          3:       emit(OP_LD, 8'h80 | rand_bits(5));
          default: emit(OP_ST, 8'h80 | rand_bits(5));
        endcase
      end
      emit(OP_ST, `TOHOST_ADDR);
      run_test(boot);
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/core_sys_chk.sv
`default_nettype none

module core_sys_chk
  import core_trace_pkg::*;
(
  input logic         clk_i,
  input logic         rst_n_i,
  input logic         retire_valid_i,
  input logic         mem_req_i,
  input exit_status_e exit_status_i,
  input logic [15:0]  retire_count_i
);

  // ----------------------------------------
  // Reset and end-of-test rules
  // ----------------------------------------

  // FSM state is only defined after the first reset edge
  a_no_retire_in_reset: assert property (
    @(posedge clk_i) (!rst_n_i && !$past(rst_n_i)) |-> !retire_valid_i
  ) else $error("Retire strobe while in reset");

  a_exit_stable: assert property (
    @(posedge clk_i) (rst_n_i && $past(rst_n_i) && ($past(exit_status_i) != EXIT_NONE))
      |-> (exit_status_i == $past(exit_status_i))
  ) else $error("Exit status changed before reset");

  // Only the cycle where the exit first rises may carry a request
  a_no_req_after_exit: assert property (
    @(posedge clk_i) (rst_n_i && (exit_status_i != EXIT_NONE) &&
                      ($past(exit_status_i) != EXIT_NONE)) |-> !mem_req_i
  ) else $error("Memory request after exit");

  a_count_monotonic: assert property (
    @(posedge clk_i) (rst_n_i && $past(rst_n_i))
      |-> (retire_count_i >= $past(retire_count_i))
  ) else $error("Retire count decreased");

endmodule

bind core_sys_top core_sys_chk u_chk (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .retire_valid_i (retire_valid),
  .mem_req_i      (mem_req),
  .exit_status_i  (exit_status),
  .retire_count_i (retire_count_o)
);

`default_nettype wire

// File: design/core_sys_top.sv
`default_nettype none

`include "core_cfg.svh"

module core_sys_top
  import core_trace_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [`CORE_AW-1:0] boot_addr_i,

  input  logic                load_we_i,
  input  logic [`CORE_AW-1:0] load_addr_i,
  input  logic [`CORE_DW-1:0] load_data_i,

  output exit_status_e        exit_status_o,
  output logic [`CORE_DW-1:0] exit_code_o,
  output logic [15:0]         retire_count_o
);

  logic                mem_req;
  logic                mem_we;
  logic [`CORE_AW-1:0] mem_addr;
  logic [`CORE_DW-1:0] mem_wdata;
  logic [`CORE_DW-1:0] mem_rdata;

  logic                retire_valid;
  logic [`CORE_AW-1:0] retire_pc;
  logic [`CORE_DW-1:0] retire_insn;
  logic                retire_st;
  logic [`CORE_AW-1:0] retire_st_addr;
  logic [`CORE_DW-1:0] retire_st_data;
  logic                retire_illegal;

  exit_status_e        exit_status;

  // ----------------------------------------
  // Core
  // ----------------------------------------

  acc_core u_core (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .boot_addr_i      (boot_addr_i),
    .mem_rdata_i      (mem_rdata),
    .halt_i           (exit_status),
    .mem_req_o        (mem_req),
    .mem_we_o         (mem_we),
    .mem_addr_o       (mem_addr),
    .mem_wdata_o      (mem_wdata),
    .retire_valid_o   (retire_valid),
    .retire_pc_o      (retire_pc),
    .retire_insn_o    (retire_insn),
    .retire_st_o      (retire_st),
    .retire_st_addr_o (retire_st_addr),
    .retire_st_data_o (retire_st_data),
    .retire_illegal_o (retire_illegal)
  );

  // ----------------------------------------
  // Memory
  // ----------------------------------------

  word_sram u_sram (
    .clk_i       (clk_i),
    .req_i       (mem_req),
    .we_i        (mem_we),
    .addr_i      (mem_addr),
    .wdata_i     (mem_wdata),
    .rdata_o     (mem_rdata),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i)
  );

  // ----------------------------------------
  // Retirement tracer
  // ----------------------------------------

  commit_tracer u_tracer (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .retire_valid_i   (retire_valid),
    .retire_pc_i      (retire_pc),
    .retire_insn_i    (retire_insn),
    .retire_st_i      (retire_st),
    .retire_st_addr_i (retire_st_addr),
    .retire_st_data_i (retire_st_data),
    .retire_illegal_i (retire_illegal),
    .exit_status_o    (exit_status),
    .exit_code_o      (exit_code_o),
    .retire_count_o   (retire_count_o)
  );

  assign exit_status_o = exit_status;

endmodule

`default_nettype wire

// File: design/commit_tracer.sv
`default_nettype none

`include "core_cfg.svh"

module commit_tracer
  import core_isa_pkg::*;
  import core_trace_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  logic                retire_valid_i,
  input  logic [`CORE_AW-1:0] retire_pc_i,
  input  logic [`CORE_DW-1:0] retire_insn_i,
  input  logic                retire_st_i,
  input  logic [`CORE_AW-1:0] retire_st_addr_i,
  input  logic [`CORE_DW-1:0] retire_st_data_i,
  input  logic                retire_illegal_i,

  output exit_status_e        exit_status_o,
  output logic [`CORE_DW-1:0] exit_code_o,
  output logic [15:0]         retire_count_o
);

  exit_status_e        status_q;
  logic [`CORE_DW-1:0] code_q;
  logic [15:0]         count_q;
  logic                hit_tohost;
  logic                hit_illegal;

  // Store record must also carry a store opcode
  assign hit_tohost  = retire_valid_i && retire_st_i &&
                       (retire_st_addr_i == `TOHOST_ADDR) &&
                       (retire_insn_i[`CORE_DW-1 -: 4] == OP_ST);
  assign hit_illegal = retire_valid_i && retire_illegal_i;

  // ----------------------------------------
  // Counter and exit latch
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      status_q <= EXIT_NONE;
      code_q   <= '0;
      count_q  <= '0;
    end else if (status_q == EXIT_NONE) begin
      if (retire_valid_i) begin
        count_q <= count_q + 16'd1;
      end
      if (hit_illegal) begin
        status_q <= EXIT_ILLEGAL;
        code_q   <= {{(`CORE_DW - `CORE_AW){1'b0}}, retire_pc_i};
      end else if (hit_tohost) begin
        status_q <= EXIT_TOHOST;
        code_q   <= retire_st_data_i;
      end
    end
  end

  // Frozen once an exit is latched
  assign exit_status_o  = status_q;
  assign exit_code_o    = code_q;
  assign retire_count_o = count_q;

endmodule

`default_nettype wire

// File: design/word_sram.sv
`default_nettype none

`include "core_cfg.svh"

module word_sram (
  input  logic                clk_i,

  // Core port
  input  logic                req_i,
  input  logic                we_i,
  input  logic [`CORE_AW-1:0] addr_i,
  input  logic [`CORE_DW-1:0] wdata_i,
  output logic [`CORE_DW-1:0] rdata_o,

  // Preload port
  input  logic                load_we_i,
  input  logic [`CORE_AW-1:0] load_addr_i,
  input  logic [`CORE_DW-1:0] load_data_i
);

  logic [`CORE_DW-1:0] mem_q [`MEM_WORDS];
  logic [`CORE_DW-1:0] rdata_q;

  // ----------------------------------------
  // Array writes
  // ----------------------------------------

  // Preload comes last so it wins on an address clash
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    if (load_we_i) begin
      mem_q[load_addr_i] <= load_data_i;
    end
  end

  // Registered read, one cycle after the request
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: design/acc_core.sv
`default_nettype none

`include "core_cfg.svh"

module acc_core
  import core_isa_pkg::*;
  import core_trace_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [`CORE_AW-1:0] boot_addr_i,
  input  logic [`CORE_DW-1:0] mem_rdata_i,
  input  exit_status_e        halt_i,

  output logic                mem_req_o,
  output logic                mem_we_o,
  output logic [`CORE_AW-1:0] mem_addr_o,
  output logic [`CORE_DW-1:0] mem_wdata_o,

  output logic                retire_valid_o,
  output logic [`CORE_AW-1:0] retire_pc_o,
  output logic [`CORE_DW-1:0] retire_insn_o,
  output logic                retire_st_o,
  output logic [`CORE_AW-1:0] retire_st_addr_o,
  output logic [`CORE_DW-1:0] retire_st_data_o,
  output logic                retire_illegal_o
);

  core_state_e         state_q;
  logic [`CORE_AW-1:0] pc_q;
  logic [`CORE_DW-1:0] acc_q;
  logic [`CORE_DW-1:0] insn_q;

  logic [`CORE_DW-1:0] cur_insn;
  opcode_e             op;
  logic                op_legal;
  logic [`CORE_AW-1:0] operand;
  logic [`CORE_DW-1:0] operand_ext;
  logic [`CORE_AW-1:0] pc_inc;

  // ----------------------------------------
  // Decode
  // ----------------------------------------

  // In LOAD the memory returns data, so decode from the held word
  assign cur_insn    = (state_q == ST_LOAD) ? insn_q : mem_rdata_i;
  assign op          = opcode_e'(cur_insn[`CORE_DW-1 -: 4]);
  assign operand     = cur_insn[`CORE_AW-1:0];
  assign operand_ext = {{(`CORE_DW - `CORE_AW){1'b0}}, operand};
  assign pc_inc      = pc_q + 1'b1;

  always_comb begin
    case (op)
      OP_LDI, OP_ADDI, OP_SUBI, OP_LD, OP_ST, OP_BNZ: op_legal = 1'b1;
      default:                                        op_legal = 1'b0;
    endcase
  end

  // ----------------------------------------
  // Memory port
  // ----------------------------------------

  // No fetch in reset, and fetch stops as soon as the tracer reports an exit
  assign mem_req_o   = (rst_n_i && (state_q == ST_FETCH) && (halt_i == EXIT_NONE)) ||
                       ((state_q == ST_EXEC) && ((op == OP_LD) || (op == OP_ST)));
  assign mem_we_o    = (state_q == ST_EXEC) && (op == OP_ST);
  assign mem_addr_o  = (state_q == ST_EXEC) ? operand : pc_q;
  assign mem_wdata_o = acc_q;

  // ----------------------------------------
  // Retirement port
  // ----------------------------------------

  // Loads retire in LOAD, everything else in EXEC
  assign retire_valid_o   = ((state_q == ST_EXEC) && (op != OP_LD)) ||
                            (state_q == ST_LOAD);
  assign retire_pc_o      = pc_q;
  assign retire_insn_o    = cur_insn;
  assign retire_st_o      = (state_q == ST_EXEC) && (op == OP_ST);
  assign retire_st_addr_o = operand;
  assign retire_st_data_o = acc_q;
  assign retire_illegal_o = (state_q == ST_EXEC) && !op_legal;

  // Held for the retire record of a load
  always_ff @(posedge clk_i) begin
    if (state_q == ST_EXEC) begin
      insn_q <= mem_rdata_i;
    end
  end

  // ----------------------------------------
  // Control FSM, PC and accumulator
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_FETCH;
      pc_q    <= boot_addr_i;
      acc_q   <= '0;
    end else begin
      case (state_q)
        ST_FETCH: begin
          state_q <= (halt_i != EXIT_NONE) ? ST_HALT : ST_EXEC;
        end
        ST_EXEC: begin
          state_q <= ST_FETCH;
          case (op)
            OP_LDI: begin
              acc_q <= operand_ext;
              pc_q  <= pc_inc;
            end
            OP_ADDI: begin
              acc_q <= acc_q + operand_ext;
              pc_q  <= pc_inc;
            end
            OP_SUBI: begin
              acc_q <= acc_q - operand_ext;
              pc_q  <= pc_inc;
            end
            OP_LD: begin
              state_q <= ST_LOAD;
            end
            OP_ST: begin
              pc_q <= pc_inc;
            end
            OP_BNZ: begin
              pc_q <= (acc_q != '0) ? operand : pc_inc;
            end
            default: begin
              // Illegal opcode keeps its PC for the exit code
              pc_q <= pc_q;
            end
          endcase
        end
        ST_LOAD: begin
          acc_q   <= mem_rdata_i;
          pc_q    <= pc_inc;
          state_q <= ST_FETCH;
        end
        ST_HALT: begin
          state_q <= ST_HALT;
        end
        default: begin
          state_q <= ST_HALT;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/core_trace_pkg.sv
`default_nettype none

package core_trace_pkg;

  // End-of-test status raised by the tracer
  typedef enum logic [1:0] {
    EXIT_NONE    = 2'd0,
    EXIT_TOHOST  = 2'd1,
    EXIT_ILLEGAL = 2'd2
  } exit_status_e;

endpackage

`default_nettype wire

// File: design/core_isa_pkg.sv
`default_nettype none

package core_isa_pkg;

  // ----------------------------------------
  // Instruction set
  // ----------------------------------------

  // Opcode lives in insn[15:12], operand in insn[7:0]
  // Code 0 and codes 7..15 are illegal
  typedef enum logic [3:0] {
    OP_LDI  = 4'h1,
    OP_ADDI = 4'h2,
    OP_SUBI = 4'h3,
    OP_LD   = 4'h4,
    OP_ST   = 4'h5,
    OP_BNZ  = 4'h6
  } opcode_e;

  // ----------------------------------------
  // Core control
  // ----------------------------------------

  typedef enum logic [1:0] {
    ST_FETCH = 2'd0,  // read request at the PC
    ST_EXEC  = 2'd1,  // instruction word arrives
    ST_LOAD  = 2'd2,  // load data arrives
    ST_HALT  = 2'd3
  } core_state_e;

endpackage

`default_nettype wire

// File: design/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath and instruction width
`define CORE_DW 16

// Word address width, also the operand field width
`define CORE_AW 8

// Memory depth in words
`define MEM_WORDS 256

// A retired store to this address ends the test
`define TOHOST_ADDR 8'hFF

`endif
